// ==== dv/id_ref.svh ====
`ifndef ID_REF_SVH
`define ID_REF_SVH

// Operand shape of each decoded instruction
localparam logic [3:0] K_NONE  = 4'd0;
localparam logic [3:0] K_R3    = 4'd1;
localparam logic [3:0] K_TRAP  = 4'd2;
localparam logic [3:0] K_I12S  = 4'd3;
localparam logic [3:0] K_I12Z  = 4'd4;
localparam logic [3:0] K_STORE = 4'd5;
localparam logic [3:0] K_JIRL  = 4'd6;
localparam logic [3:0] K_BCC   = 4'd7;
localparam logic [3:0] K_U20   = 4'd8;
localparam logic [3:0] K_B     = 4'd9;
localparam logic [3:0] K_BL    = 4'd10;
localparam logic [3:0] K_CSR   = 4'd11;
localparam logic [3:0] K_PRIV  = 4'd12;

function automatic id_dispatch_t ref_decode(input instr_buffer_info_t info,
                                            input logic [1:0] plv,
                                            input logic intr);
    logic [31:0]  w;
    logic [7:0]   op;
    logic [2:0]   sel;
    logic [3:0]   kind;
    logic [4:0]   rd;
    logic [4:0]   rj;
    logic [4:0]   rk;
    logic [31:0]  sext12;
    logic [31:0]  b16;
    logic [31:0]  b26;
    id_dispatch_t d;
    w = info.instr;
    rd = w[4:0];
    rj = w[9:5];
    rk = w[14:10];
    sext12 = {{20{w[21]}}, w[21:10]};
    b16 = {{14{w[25]}}, w[25:10], 2'b00};
    b26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
    {op, sel, kind} = {OP_NOP, SEL_NONE, K_NONE};
    if (info.valid) begin
        case (w[31:15])
            17'h00020: {op, sel, kind} = {OP_ADD, SEL_ARITH, K_R3};
            17'h00022: {op, sel, kind} = {OP_SUB, SEL_ARITH, K_R3};
            17'h00024: {op, sel, kind} = {OP_SLT, SEL_ARITH, K_R3};
            17'h00025: {op, sel, kind} = {OP_SLTU, SEL_ARITH, K_R3};
            17'h00028: {op, sel, kind} = {OP_NOR, SEL_LOGIC, K_R3};
            17'h00029: {op, sel, kind} = {OP_AND, SEL_LOGIC, K_R3};
            17'h0002a: {op, sel, kind} = {OP_OR, SEL_LOGIC, K_R3};
            17'h0002b: {op, sel, kind} = {OP_XOR, SEL_LOGIC, K_R3};
            17'h0002e: {op, sel, kind} = {OP_SLL, SEL_SHIFT, K_R3};
            17'h0002f: {op, sel, kind} = {OP_SRL, SEL_SHIFT, K_R3};
            17'h00030: {op, sel, kind} = {OP_SRA, SEL_SHIFT, K_R3};
            17'h00054: {op, sel, kind} = {OP_BREAK, SEL_NONE, K_TRAP};
            17'h00056: {op, sel, kind} = {OP_SYSCALL, SEL_NONE, K_TRAP};
            17'h00c91: {op, sel, kind} = {OP_IDLE, SEL_CSR, K_PRIV};
            default: ;
        endcase
        case (w[31:22])
            10'h008: {op, sel, kind} = {OP_SLT, SEL_ARITH, K_I12S};
            10'h009: {op, sel, kind} = {OP_SLTU, SEL_ARITH, K_I12S};
            10'h00a: {op, sel, kind} = {OP_ADD, SEL_ARITH, K_I12S};
            10'h00d: {op, sel, kind} = {OP_AND, SEL_LOGIC, K_I12Z};
            10'h00e: {op, sel, kind} = {OP_OR, SEL_LOGIC, K_I12Z};
            10'h00f: {op, sel, kind} = {OP_XOR, SEL_LOGIC, K_I12Z};
            10'h0a2: {op, sel, kind} = {OP_LD_W, SEL_MEM, K_I12S};
            10'h0a6: {op, sel, kind} = {OP_ST_W, SEL_MEM, K_STORE};
            default: ;
        endcase
        case (w[31:26])
            6'h13:   {op, sel, kind} = {OP_JIRL, SEL_BRANCH, K_JIRL};
            6'h14:   {op, sel, kind} = {OP_B, SEL_BRANCH, K_B};
            6'h15:   {op, sel, kind} = {OP_BL, SEL_BRANCH, K_BL};
            6'h16:   {op, sel, kind} = {OP_BEQ, SEL_BRANCH, K_BCC};
            6'h17:   {op, sel, kind} = {OP_BNE, SEL_BRANCH, K_BCC};
            default: ;
        endcase
        case (w[31:25])
            7'h0a:   {op, sel, kind} = {OP_LU12I, SEL_MOVE, K_U20};
            7'h0e:   {op, sel, kind} = {OP_PCADDU12I, SEL_ARITH, K_U20};
            default: ;
        endcase
        if (w[31:24] == 8'h04) begin
            op = (rj == 5'd0) ? OP_CSRRD : (rj == 5'd1) ? OP_CSRWR : OP_CSRXCHG;
            sel = SEL_CSR;
            kind = K_CSR;
        end
        if (w == 32'h0648_3800) begin
            {op, sel, kind} = {OP_ERTN, SEL_CSR, K_PRIV};
        end
    end

    d = '0;
    d.instr_info = info;
    d.aluop = aluop_e'(op);
    d.alusel = alusel_e'(sel);
    d.use_imm = !(kind inside {K_NONE, K_R3, K_TRAP, K_PRIV});
    case (kind)
        K_R3: begin
            d.reg_read_valid = 2'b11;
            d.reg_read_addr = {rk, rj};
            d.reg_write_valid = 1'b1;
            d.reg_write_addr = rd;
        end
        K_I12S, K_I12Z: begin
            d.reg_read_valid = 2'b01;
            d.reg_read_addr = {5'd0, rj};
            d.reg_write_valid = 1'b1;
            d.reg_write_addr = rd;
            d.imm = (kind == K_I12S) ? sext12 : {20'b0, w[21:10]};
        end
        K_STORE: begin
            d.reg_read_valid = 2'b11;
            d.reg_read_addr = {rd, rj};
            d.imm = sext12;
        end
        K_JIRL: begin
            d.reg_read_valid = 2'b01;
            d.reg_read_addr = {5'd0, rj};
            d.reg_write_valid = 1'b1;
            d.reg_write_addr = rd;
            d.imm = b16;
        end
        K_BCC: begin
            d.reg_read_valid = 2'b11;
            d.reg_read_addr = {rd, rj};
            d.imm = b16;
        end
        K_U20: begin
            d.reg_write_valid = 1'b1;
            d.reg_write_addr = rd;
            d.imm = {w[24:5], 12'b0};
        end
        K_B, K_BL: begin
            d.reg_write_valid = (kind == K_BL);
            d.reg_write_addr = (kind == K_BL) ? 5'd1 : 5'd0;
            d.imm = b26;
        end
        K_CSR: begin
            d.reg_write_valid = 1'b1;
            d.reg_write_addr = rd;
            d.imm = {18'b0, w[23:10]};
            if (op == OP_CSRWR) begin
                d.reg_read_valid = 2'b01;
                d.reg_read_addr = {5'd0, rd};
            end else if (op == OP_CSRXCHG) begin
                d.reg_read_valid = 2'b11;
                d.reg_read_addr = {rj, rd};
            end
        end
        default: ;
    endcase

    if (info.valid) begin
        d.excp_num.ipe = (sel == SEL_CSR) && (plv == PLV_USER);
        d.excp_num.ine = (kind == K_NONE);
        d.excp_num.brk = (op == OP_BREAK);
        d.excp_num.sys = (op == OP_SYSCALL);
        d.excp_num.fetch = info.fetch_excp;
        d.excp_num.intr = intr;
    end
    d.excp = |d.excp_num;
    d.refetch = op inside {OP_CSRWR, OP_CSRXCHG, OP_ERTN};
    return d;
endfunction

`endif

// ==== dv/id_tb.sv ====
`timescale 1ns/100ps

module id_tb
    import decode_pkg::*;
;

    localparam int NUM_INSTR = 3000;
    localparam int WATCHDOG_NS = NUM_INSTR * 4 * 10 + 2000;

    localparam logic [16:0] R3_CODES [13] = '{
        17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029, 17'h0002a,
        17'h0002b, 17'h0002e, 17'h0002f, 17'h00030, 17'h00054, 17'h00056
    };
    localparam logic [9:0] I12_CODES [8] = '{
        10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f, 10'h0a2, 10'h0a6
    };
    localparam logic [5:0] I16_CODES [5] = '{6'h13, 6'h14, 6'h15, 6'h16, 6'h17};

    logic               clk;
    logic               reset_i;
    logic               stall_i;
    instr_buffer_info_t instr_buffer_i;
    logic               has_int_i;
    logic [1:0]         csr_plv_i;
    id_dispatch_t       dispatch_o;

    id_dispatch_t       exp_q[$];
    instr_buffer_info_t model_buf;
    logic               out_loaded;
    int                 sent;
    int                 received;
    int                 errors;

    `include "id_ref.svh"

    id_stage_top dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .instr_buffer_i(instr_buffer_i),
        .has_int_i     (has_int_i),
        .csr_plv_i     (csr_plv_i),
        .dispatch_o    (dispatch_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Mostly table opcodes with random fields and some raw random words
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  rj;
        int          pick;
        int          idx;
        r = $urandom;
        w = r;
        pick = $urandom_range(0, 9);
        case (pick)
            0, 1: begin
                idx = $urandom_range(0, 12);
                w = {R3_CODES[idx], r[14:0]};
            end
            2, 3: begin
                idx = $urandom_range(0, 7);
                w = {I12_CODES[idx], r[21:0]};
            end
            4, 5: begin
                idx = $urandom_range(0, 4);
                w = {I16_CODES[idx], r[25:0]};
            end
            6: w = {($urandom_range(0, 1) == 0) ? 7'h0a : 7'h0e, r[24:0]};
            7: begin
                // rj picks csrrd, csrwr or csrxchg
                case ($urandom_range(0, 2))
                    0:       rj = 5'd0;
                    1:       rj = 5'd1;
                    default: rj = r[9:5];
                endcase
                w = {8'h04, r[23:10], rj, r[4:0]};
            end
            8: w = ($urandom_range(0, 1) == 0) ? 32'h0648_3800 : {17'h00c91, r[14:0]};
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_random();
        instr_buffer_info_t info;
        logic [31:0]        r;
        r = $urandom;
        info.valid = ($urandom_range(0, 7) != 0);
        info.pc = {r[31:2], 2'b00};
        info.instr = random_instr();
        info.is_last_in_block = ($urandom_range(0, 1) == 1);
        info.fetch_excp = ($urandom_range(0, 7) == 0) ? r[3:0] : 4'b0;
        instr_buffer_i = info;
        stall_i = ($urandom_range(0, 3) == 0);
        has_int_i = ($urandom_range(0, 15) == 0);
        csr_plv_i = ($urandom_range(0, 1) == 1) ? PLV_USER : 2'd0;
        if (info.valid && !stall_i) begin
            sent++;
        end
    endtask

    // Model of the input register
    // Expected result is formed when the output register loads
    always @(posedge clk) begin
        if (reset_i) begin
            model_buf = '0;
            out_loaded = 1'b0;
        end else if (!stall_i) begin
            if (model_buf.valid) begin
                exp_q.push_back(ref_decode(model_buf, csr_plv_i, has_int_i));
            end
            model_buf = instr_buffer_i;
            out_loaded = 1'b1;
        end else begin
            out_loaded = 1'b0;
        end
    end

    always @(negedge clk) begin : compare_output
        id_dispatch_t expected;
        if (out_loaded) begin
            if (dispatch_o.instr_info.valid) begin
                received++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected instruction at %0d ns: pc %h arrived with nothing pending",
                             $time, dispatch_o.instr_info.pc);
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    if (dispatch_o !== expected) begin
                        $display("CHECK FAILED at %0d ns: instr %h pc %h got %h expected %h",
                                 $time, expected.instr_info.instr, expected.instr_info.pc,
                                 dispatch_o, expected);
                        errors++;
                    end
                end
            end else if (dispatch_o.excp || dispatch_o.excp_num != '0) begin
                $display("CHECK FAILED at %0d ns: empty slot carries exception bits %b",
                         $time, dispatch_o.excp_num);
                errors++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns: only %0d of %0d instructions came out",
                 WATCHDOG_NS, received, NUM_INSTR);
        $display("Summary: sent %0d, received %0d, errors %0d", sent, received, errors + 1);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'hd57f));
        reset_i = 1'b1;
        stall_i = 1'b0;
        // A valid slot during reset must not reach the output
        instr_buffer_i = '0;
        instr_buffer_i.valid = 1'b1;
        has_int_i = 1'b0;
        csr_plv_i = 2'd0;
        out_loaded = 1'b0;
        model_buf = '0;
        sent = 0;
        received = 0;
        errors = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        instr_buffer_i = '0;
        if (dispatch_o.instr_info.valid !== 1'b0) begin
            $display("CHECK FAILED at %0d ns: dispatch valid high after reset", $time);
            errors++;
        end

        while (sent < NUM_INSTR) begin
            @(negedge clk);
            drive_random();
        end
        @(negedge clk);
        instr_buffer_i = '0;
        stall_i = 1'b0;
        has_int_i = 1'b0;
        while (received < NUM_INSTR) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("Lost instructions: %0d expected results never came out", exp_q.size());
            errors++;
        end
        if (received != sent) begin
            $display("Count mismatch: sent %0d instructions but received %0d", sent, received);
            errors++;
        end
        $display("Summary: sent %0d, received %0d, errors %0d", sent, received, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
hw/decode_pkg.sv
hw/decoder_3r.sv
hw/decoder_2ri12.sv
hw/decoder_2ri16.sv
hw/decoder_long_imm.sv
hw/decoder_csr.sv
hw/id.sv
hw/id_stage_top.sv
dv/id_tb.sv

// ==== hw/decode_pkg.sv ====
package decode_pkg;

    localparam int REG_NUM_LOG2 = 5;
    localparam logic [1:0] PLV_USER = 2'd3;

    typedef struct packed {
        logic [16:0]             opcode;
        logic [REG_NUM_LOG2-1:0] rk;
        logic [REG_NUM_LOG2-1:0] rj;
        logic [REG_NUM_LOG2-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]              opcode;
        logic [11:0]             si12;
        logic [REG_NUM_LOG2-1:0] rj;
        logic [REG_NUM_LOG2-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [15:0]             offs16;
        logic [REG_NUM_LOG2-1:0] rj;
        logic [REG_NUM_LOG2-1:0] rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]              opcode;
        logic [19:0]             si20;
        logic [REG_NUM_LOG2-1:0] rd;
    } fmt_1ri20_t;

    // Offset high bits sit in the lowest field
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_2ri16_t ri16;
        fmt_1ri20_t ri20;
        fmt_i26_t   i26;
    } instr_u;

    // NOP must stay zero for the OR merge
    typedef enum logic [7:0] {
        OP_NOP = 8'd0,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_NOR, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_BREAK, OP_SYSCALL,
        OP_LD_W, OP_ST_W,
        OP_JIRL, OP_BEQ, OP_BNE, OP_B, OP_BL,
        OP_LU12I, OP_PCADDU12I,
        OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN, OP_IDLE
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NONE = 3'd0,
        SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE, SEL_BRANCH, SEL_MEM, SEL_CSR
    } alusel_e;

    typedef struct packed {
        logic adef;
        logic tlbr;
        logic pif;
        logic ppi;
    } fetch_excp_t;

    typedef struct packed {
        logic        ipe;
        logic        ine;
        logic        brk;
        logic        sys;
        fetch_excp_t fetch;
        logic        intr;
    } excp_num_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_u      instr;
        logic        is_last_in_block;
        fetch_excp_t fetch_excp;
    } instr_buffer_info_t;

    typedef struct packed {
        logic                      hit;
        aluop_e                    aluop;
        alusel_e                   alusel;
        logic [1:0]                reg_read_valid;
        logic [REG_NUM_LOG2*2-1:0] reg_read_addr;
        logic                      reg_write_valid;
        logic [REG_NUM_LOG2-1:0]   reg_write_addr;
        logic                      use_imm;
        logic [31:0]               imm;
    } sub_decode_t;

    typedef struct packed {
        instr_buffer_info_t        instr_info;
        aluop_e                    aluop;
        alusel_e                   alusel;
        logic [1:0]                reg_read_valid;
        logic [REG_NUM_LOG2*2-1:0] reg_read_addr;
        logic                      reg_write_valid;
        logic [REG_NUM_LOG2-1:0]   reg_write_addr;
        logic                      use_imm;
        logic [31:0]               imm;
        logic                      refetch;
        logic                      excp;
        excp_num_t                 excp_num;
    } id_dispatch_t;

endpackage

// ==== hw/decoder_2ri12.sv ====
`timescale 1ns/100ps

module decoder_2ri12
    import decode_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    instr_u  instr;
    aluop_e  op;
    alusel_e sel;
    logic    zero_ext;

    assign instr = instr_info_i.instr;

    always_comb begin
        op = OP_NOP;
        if (instr_info_i.valid) begin
            case (instr.ri12.opcode)
                10'h008: op = OP_SLT;
                10'h009: op = OP_SLTU;
                10'h00a: op = OP_ADD;
                10'h00d: op = OP_AND;
                10'h00e: op = OP_OR;
                10'h00f: op = OP_XOR;
                10'h0a2: op = OP_LD_W;
                10'h0a6: op = OP_ST_W;
                default: op = OP_NOP;
            endcase
        end
    end

    always_comb begin
        case (op)
            OP_SLT, OP_SLTU, OP_ADD: sel = SEL_ARITH;
            OP_AND, OP_OR, OP_XOR:   sel = SEL_LOGIC;
            OP_LD_W, OP_ST_W:        sel = SEL_MEM;
            default:                 sel = SEL_NONE;
        endcase
    end

    // Logic immediates are unsigned
    assign zero_ext = (sel == SEL_LOGIC);

    always_comb begin
        result_o = '0;
        if (op != OP_NOP) begin
            result_o.hit = 1'b1;
            result_o.aluop = op;
            result_o.alusel = sel;
            result_o.use_imm = 1'b1;
            result_o.imm = zero_ext ? {20'b0, instr.ri12.si12}
                                    : {{20{instr.ri12.si12[11]}}, instr.ri12.si12};
            if (op == OP_ST_W) begin
                result_o.reg_read_valid = 2'b11;
                result_o.reg_read_addr = {instr.ri12.rd, instr.ri12.rj};
            end else begin
                result_o.reg_read_valid = 2'b01;
                result_o.reg_read_addr = {{REG_NUM_LOG2{1'b0}}, instr.ri12.rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr = instr.ri12.rd;
            end
        end
    end

endmodule

// ==== hw/decoder_2ri16.sv ====
`timescale 1ns/100ps

module decoder_2ri16
    import decode_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    instr_u instr;
    aluop_e op;

    assign instr = instr_info_i.instr;

    always_comb begin
        op = OP_NOP;
        if (instr_info_i.valid) begin
            case (instr.ri16.opcode)
                6'h13:   op = OP_JIRL;
                6'h16:   op = OP_BEQ;
                6'h17:   op = OP_BNE;
                default: op = OP_NOP;
            endcase
        end
    end

    always_comb begin
        result_o = '0;
        if (op != OP_NOP) begin
            result_o.hit = 1'b1;
            result_o.aluop = op;
            result_o.alusel = SEL_BRANCH;
            result_o.use_imm = 1'b1;
            // Word offset
            result_o.imm = {{14{instr.ri16.offs16[15]}}, instr.ri16.offs16, 2'b00};
            if (op == OP_JIRL) begin
                result_o.reg_read_valid = 2'b01;
                result_o.reg_read_addr = {{REG_NUM_LOG2{1'b0}}, instr.ri16.rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr = instr.ri16.rd;
            end else begin
                result_o.reg_read_valid = 2'b11;
                result_o.reg_read_addr = {instr.ri16.rd, instr.ri16.rj};
            end
        end
    end

endmodule

// ==== hw/decoder_3r.sv ====
`timescale 1ns/100ps

module decoder_3r
    import decode_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o,
    output logic               brk_o,
    output logic               sys_o
);

    instr_u  instr;
    aluop_e  op;
    alusel_e sel;

    assign instr = instr_info_i.instr;

    always_comb begin
        op = OP_NOP;
        if (instr_info_i.valid) begin
            case (instr.r3.opcode)
                17'h00020: op = OP_ADD;
                17'h00022: op = OP_SUB;
                17'h00024: op = OP_SLT;
                17'h00025: op = OP_SLTU;
                17'h00028: op = OP_NOR;
                17'h00029: op = OP_AND;
                17'h0002a: op = OP_OR;
                17'h0002b: op = OP_XOR;
                17'h0002e: op = OP_SLL;
                17'h0002f: op = OP_SRL;
                17'h00030: op = OP_SRA;
                17'h00054: op = OP_BREAK;
                17'h00056: op = OP_SYSCALL;
                default:   op = OP_NOP;
            endcase
        end
    end

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU: sel = SEL_ARITH;
            OP_NOR, OP_AND, OP_OR, OP_XOR:   sel = SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:          sel = SEL_SHIFT;
            default:                         sel = SEL_NONE;
        endcase
    end

    assign brk_o = (op == OP_BREAK);
    assign sys_o = (op == OP_SYSCALL);

    always_comb begin
        result_o = '0;
        if (op != OP_NOP) begin
            result_o.hit = 1'b1;
            result_o.aluop = op;
            result_o.alusel = sel;
            // Traps carry a code in the register fields, nothing to read
            if (!brk_o && !sys_o) begin
                result_o.reg_read_valid = 2'b11;
                result_o.reg_read_addr = {instr.r3.rk, instr.r3.rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr = instr.r3.rd;
            end
        end
    end

endmodule

// ==== hw/decoder_csr.sv ====
`timescale 1ns/100ps

module decoder_csr
    import decode_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    instr_u      instr;
    aluop_e      op;
    logic        csr_group;
    logic [13:0] csr_num;

    assign instr = instr_info_i.instr;
    // 0x04 prefix ahead of a 14-bit CSR number
    assign csr_group = (instr.ri16.opcode == 6'h01) && (instr.ri16.offs16[15:14] == 2'b00);
    assign csr_num = instr.ri16.offs16[13:0];

    always_comb begin
        op = OP_NOP;
        if (instr_info_i.valid) begin
            if (csr_group) begin
                case (instr.ri16.rj)
                    5'd0:    op = OP_CSRRD;
                    5'd1:    op = OP_CSRWR;
                    default: op = OP_CSRXCHG;
                endcase
            end else if (instr == 32'h0648_3800) begin
                op = OP_ERTN;
            end else if (instr.r3.opcode == 17'h00c91) begin
                op = OP_IDLE;
            end
        end
    end

    always_comb begin
        result_o = '0;
        result_o.hit = (op != OP_NOP);
        result_o.aluop = op;
        result_o.alusel = (op != OP_NOP) ? SEL_CSR : SEL_NONE;
        if (csr_group && op != OP_NOP) begin
            result_o.use_imm = 1'b1;
            result_o.imm = {18'b0, csr_num};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr = instr.ri16.rd;
            // csrwr reads rd and csrxchg also reads the mask in rj
            result_o.reg_read_valid = (op == OP_CSRXCHG) ? 2'b11 : {1'b0, op == OP_CSRWR};
            result_o.reg_read_addr = (op == OP_CSRRD) ? '0 : {instr.ri16.rj, instr.ri16.rd};
            if (op == OP_CSRWR) begin
                result_o.reg_read_addr = {{REG_NUM_LOG2{1'b0}}, instr.ri16.rd};
            end
        end
    end

    hit_needs_valid_a: assert final (!result_o.hit || instr_info_i.valid)
        else $error("CSR decoder hit on an invalid slot");

endmodule

// ==== hw/decoder_long_imm.sv ====
`timescale 1ns/100ps

module decoder_long_imm
    import decode_pkg::*;
(
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    instr_u      instr;
    aluop_e      op;
    logic [25:0] offs26;

    assign instr = instr_info_i.instr;
    assign offs26 = {instr.i26.offs_hi, instr.i26.offs_lo};

    always_comb begin
        op = OP_NOP;
        if (instr_info_i.valid) begin
            case (instr.ri20.opcode)
                7'h0a:   op = OP_LU12I;
                7'h0e:   op = OP_PCADDU12I;
                default: op = OP_NOP;
            endcase
            case (instr.i26.opcode)
                6'h14:   op = OP_B;
                6'h15:   op = OP_BL;
                default: ;
            endcase
        end
    end

    always_comb begin
        result_o = '0;
        result_o.hit = (op != OP_NOP);
        result_o.aluop = op;
        result_o.use_imm = (op != OP_NOP);
        case (op)
            OP_LU12I, OP_PCADDU12I: begin
                result_o.alusel = (op == OP_LU12I) ? SEL_MOVE : SEL_ARITH;
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr = instr.ri20.rd;
                result_o.imm = {instr.ri20.si20, 12'b0};
            end
            OP_B, OP_BL: begin
                result_o.alusel = SEL_BRANCH;
                // Link register is r1
                result_o.reg_write_valid = (op == OP_BL);
                result_o.reg_write_addr = (op == OP_BL) ? REG_NUM_LOG2'(1) : '0;
                result_o.imm = {{4{offs26[25]}}, offs26, 2'b00};
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/id.sv ====
`timescale 1ns/100ps

module id
    import decode_pkg::*;
(
    input  instr_buffer_info_t instr_buffer_i,
    input  logic               has_int_i,
    input  logic [1:0]         csr_plv_i,
    output id_dispatch_t       dispatch_o
);

    sub_decode_t res_3r;
    sub_decode_t res_2ri12;
    sub_decode_t res_2ri16;
    sub_decode_t res_long;
    sub_decode_t res_csr;
    sub_decode_t merged;
    logic [4:0]  hit_vec;
    logic        brk;
    logic        sys;
    excp_num_t   excp_num;

    decoder_3r u_decoder_3r (
        .instr_info_i(instr_buffer_i),
        .result_o    (res_3r),
        .brk_o       (brk),
        .sys_o       (sys)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_info_i(instr_buffer_i),
        .result_o    (res_2ri12)
    );

    decoder_2ri16 u_decoder_2ri16 (
        .instr_info_i(instr_buffer_i),
        .result_o    (res_2ri16)
    );

    decoder_long_imm u_decoder_long_imm (
        .instr_info_i(instr_buffer_i),
        .result_o    (res_long)
    );

    decoder_csr u_decoder_csr (
        .instr_info_i(instr_buffer_i),
        .result_o    (res_csr)
    );

    // Missing decoders drive zeros, so OR is the merge
    assign merged = sub_decode_t'(res_3r | res_2ri12 | res_2ri16 | res_long | res_csr);
    assign hit_vec = {res_3r.hit, res_2ri12.hit, res_2ri16.hit, res_long.hit, res_csr.hit};

    always_comb begin
        excp_num = '0;
        if (instr_buffer_i.valid) begin
            excp_num.ipe = res_csr.hit && (csr_plv_i == PLV_USER);
            excp_num.ine = !merged.hit;
            excp_num.brk = brk;
            excp_num.sys = sys;
            excp_num.fetch = instr_buffer_i.fetch_excp;
            excp_num.intr = has_int_i;
        end
    end

    assign dispatch_o.instr_info = instr_buffer_i;
    assign dispatch_o.aluop = merged.aluop;
    assign dispatch_o.alusel = merged.alusel;
    assign dispatch_o.reg_read_valid = merged.reg_read_valid;
    assign dispatch_o.reg_read_addr = merged.reg_read_addr;
    assign dispatch_o.reg_write_valid = merged.reg_write_valid;
    assign dispatch_o.reg_write_addr = merged.reg_write_addr;
    assign dispatch_o.use_imm = merged.use_imm;
    assign dispatch_o.imm = merged.imm;
    // CSR writes and ertn may change the fetch context
    assign dispatch_o.refetch = merged.aluop inside {OP_CSRWR, OP_CSRXCHG, OP_ERTN};
    assign dispatch_o.excp = |excp_num;
    assign dispatch_o.excp_num = excp_num;

    one_hit_a: assert final ($onehot0(hit_vec))
        else $error("More than one sub-decoder claimed the word");

endmodule

// ==== hw/id_stage_top.sv ====
`timescale 1ns/100ps

module id_stage_top
    import decode_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  instr_buffer_info_t instr_buffer_i,
    input  logic               has_int_i,
    input  logic [1:0]         csr_plv_i,
    output id_dispatch_t       dispatch_o
);

    instr_buffer_info_t buf_q;
    id_dispatch_t       id_result;
    id_dispatch_t       dispatch_q;

    id u_id (
        .instr_buffer_i(buf_q),
        .has_int_i     (has_int_i),
        .csr_plv_i     (csr_plv_i),
        .dispatch_o    (id_result)
    );

    // Both stages freeze together on stall
    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_q <= '0;
            dispatch_q <= '0;
        end else if (!stall_i) begin
            buf_q <= instr_buffer_i;
            dispatch_q <= id_result;
        end
    end

    assign dispatch_o = dispatch_q;

    reset_clears_a: assert property (@(posedge clk)
                                     $fell(reset_i) |-> !dispatch_o.instr_info.valid)
        else $error("Dispatch valid high right after reset");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module id_tb -Mdir obj_dir -o id_tb_sim
./obj_dir/id_tb_sim > sim.log 2>&1 || true
cat sim.log

# The log decides pass or fail
grep -q "^Finished with no errors$" sim.log
echo "Simulation passed"
